// File: cdc_stream.f
hdl/cdc_stream_pkg.sv
hdl/stream_packer.sv
hdl/async_fifo.sv
hdl/stream_unpacker.sv
hdl/cdc_stream_top.sv
testbench/cdc_stream_chk.sv
testbench/cdc_stream_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cdc stream testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module cdc_stream_tb -f cdc_stream.f -o cdc_stream_sim > build.log 2>&1 \
    && ./obj_dir/cdc_stream_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2> /dev/null; echo "build or simulation aborted"; exit 1; }

cat "$LOG"

grep -q "TEST FAILED" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" "$LOG" && { echo "simulation passed"; exit 0; }

echo "no result found in $LOG"
exit 1

// File: testbench/cdc_stream_tb.sv
// cdc stream testbench driving random framed traffic across two clocks against a queue model
`timescale 1ns/100ps

module cdc_stream_tb;

    localparam int ADDR_W = 4;
    localparam int DEPTH  = 1 << ADDR_W;
    localparam int LIMIT  = 2000;                 // max cycles for any single wait

    typedef logic [ADDR_W:0] count_t;

    logic                        wr_clk;
    logic                        rd_clk;
    logic                        rst_n;
    logic                        in_stb;
    cdc_stream_pkg::sample_t     in_sample;
    cdc_stream_pkg::stream_tag_t in_tag;
    logic                        full;
    count_t                      wrcount;
    cdc_stream_pkg::drop_count_t drop_count;
    logic                        out_ready;
    logic                        out_valid;
    cdc_stream_pkg::fifo_word_t  out_word;
    cdc_stream_pkg::pkt_count_t  pkt_count;
    logic                        empty;
    count_t                      rdcount;

    cdc_stream_pkg::fifo_word_t exp_q[$];         // words due at the output in arrival order
    cdc_stream_pkg::fifo_word_t pushed_log[$];    // every word the model accepted
    logic                       pend = 1'b0;      // model of the packer input stage
    cdc_stream_pkg::fifo_word_t pend_word = '0;
    int          exp_drops = 0;
    int          delivered = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          test_err0 = 0;
    bit          timed_out = 1'b0;
    int          ready_mode = 0;                  // 0 low, 1 high, 2 random
    logic [31:0] lcg_state = 32'd22;

    cdc_stream_top #(.ADDR_W(ADDR_W)) UUT (
        .rst_n      (rst_n),
        .wr_clk     (wr_clk),
        .in_stb     (in_stb),
        .in_sample  (in_sample),
        .in_tag     (in_tag),
        .full       (full),
        .wrcount    (wrcount),
        .drop_count (drop_count),
        .rd_clk     (rd_clk),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .pkt_count  (pkt_count),
        .empty      (empty),
        .rdcount    (rdcount)
    );

    initial begin
        wr_clk = 1'b0;
        forever #2 wr_clk = ~wr_clk;              // 4 ns
    end

    initial begin
        rd_clk = 1'b0;
        #0.5;                                     // rd edges never land on wr edges
        forever #3 rd_clk = ~rd_clk;              // 6 ns
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;                // upper bits since the low ones are weak
    endfunction

    // expected fifo word for a strobed sample
    function automatic cdc_stream_pkg::fifo_word_t ref_word(input cdc_stream_pkg::sample_t s,
                                                            input cdc_stream_pkg::stream_tag_t t);
        cdc_stream_pkg::fifo_word_t w;
        w.tag    = t;
        w.sample = s;
        return w;
    endfunction

    // one packet per accepted eof
    function automatic int ref_pkts();
        int n;
        n = 0;
        foreach (pushed_log[i]) begin
            if (pushed_log[i].tag.eof) n++;
        end
        return n;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR @ %0.1f ns: %s", $realtime, msg);
    endtask

    // one write clock that settles the staged word against full and then drives the next input
    task automatic wr_cycle(input logic stb, input cdc_stream_pkg::sample_t s,
                            input cdc_stream_pkg::stream_tag_t t);
        @(negedge wr_clk);
        if (pend) begin
            if (!full) begin                      // full now is what the next edge sees
                exp_q.push_back(pend_word);
                pushed_log.push_back(pend_word);
            end else begin
                exp_drops++;
            end
        end
        pend      = stb;
        pend_word = ref_word(s, t);
        in_stb    = stb;
        in_sample = s;
        in_tag    = t;
    endtask

    task automatic wr_idle(input int n);
        repeat (n) wr_cycle(1'b0, '0, '0);
    endtask

    // mode changes on a write edge and the ready driver applies it on the next rd fall
    task automatic set_ready(input int mode);
        wr_idle(1);
        ready_mode = mode;
        wr_idle(3);
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || !empty) && n < LIMIT) begin
            @(negedge rd_clk);
            n++;
        end
        if (exp_q.size() != 0 || !empty) begin
            $display("timeout: fifo never drained during %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_wrcount_zero(input string what);
        int n;
        n = 0;
        while (wrcount != '0 && n < LIMIT) begin
            @(negedge wr_clk);
            n++;
        end
        if (wrcount != '0) begin
            $display("timeout: write side count stuck above zero during %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_rdcount(input count_t target);
        int n;
        n = 0;
        while (rdcount != target && n < LIMIT) begin
            @(negedge rd_clk);
            n++;
        end
        if (rdcount != target) begin
            $display("timeout: read side count never reached %0d", target);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drops(input cdc_stream_pkg::drop_count_t target);
        int n;
        n = 0;
        while (drop_count != target && n < LIMIT) begin
            @(negedge wr_clk);
            n++;
        end
        if (drop_count != target) begin
            $display("timeout: drop counter never reached %0d", target);
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0 && !timed_out) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            $display("%s: fail, %0d errors%s", name, errors - test_err0,
                     timed_out ? ", timed out" : "");
        end
        test_err0 = errors;
    endtask

    task automatic check_idle_state(input string when);
        checks++;
        if (out_valid !== 1'b0 || empty !== 1'b1 || full !== 1'b0)
            report_error($sformatf("flags wrong %s: valid %b empty %b full %b",
                                   when, out_valid, empty, full));
        checks++;
        if (drop_count !== '0 || pkt_count !== '0 || wrcount !== '0 || rdcount !== '0)
            report_error($sformatf("counts not zero %s", when));
    endtask

    task automatic test_in_order();
        cdc_stream_pkg::stream_tag_t tag;
        logic [31:0]                 r;
        logic                        sof_next;
        sof_next = 1'b1;
        set_ready(2);
        for (int i = 0; i < 200; i++) begin
            tag.sof  = sof_next;
            tag.eof  = (rand_below(4) == 0) || (i == 199);
            sof_next = tag.eof;                   // next packet opens after an eof
            r = lcg_next();
            wr_cycle(1'b1, r[31:16], tag);
            wr_idle(2 + rand_below(5));           // slow enough that nothing drops
        end
        wait_drained("in-order traffic");
        if (timed_out) return;
        checks++;
        if (drop_count !== '0 || exp_drops != 0)
            report_error($sformatf("drops under slow traffic: dut %0d model %0d",
                                   drop_count, exp_drops));
        checks++;
        if (delivered != 200)
            report_error($sformatf("delivered %0d words, expected 200", delivered));
    endtask

    task automatic test_overflow();
        cdc_stream_pkg::stream_tag_t tag;
        cdc_stream_pkg::drop_count_t want;
        int                          delivered0;
        set_ready(0);
        wait_wrcount_zero("overflow setup");
        if (timed_out) return;
        want       = drop_count + 16'd4;
        delivered0 = delivered;
        for (int i = 0; i < 20; i++) begin
            tag.sof = (i % 4 == 0);
            tag.eof = (i % 4 == 3);
            wr_cycle(1'b1, cdc_stream_pkg::sample_t'(32'h3000 + i), tag);
            wr_idle(1);
        end
        wait_drops(want);
        if (timed_out) return;
        checks++;
        if (full !== 1'b1) report_error("full low after 20 writes with no reads");
        checks++;
        if (exp_q.size() != DEPTH || exp_q[0].sample != 16'h3000 || exp_q[15].sample != 16'h300f)
            report_error($sformatf("model kept %0d words, not the first 16", exp_q.size()));
        set_ready(1);
        wait_drained("overflow drain");
        if (timed_out) return;
        checks++;
        if (delivered - delivered0 != DEPTH)
            report_error($sformatf("overflow delivered %0d words, expected 16",
                                   delivered - delivered0));
    endtask

    task automatic test_counts();
        cdc_stream_pkg::stream_tag_t tag;
        set_ready(0);
        wait_wrcount_zero("count setup");
        if (timed_out) return;
        for (int i = 0; i < 9; i++) begin
            tag.sof = (i == 0);
            tag.eof = (i == 8);
            wr_cycle(1'b1, cdc_stream_pkg::sample_t'(32'h4000 + i), tag);
            wr_idle(1);
        end
        wait_rdcount(count_t'(9));
        if (timed_out) return;
        checks++;
        if (wrcount !== count_t'(9))
            report_error($sformatf("wrcount %0d with 9 stored", wrcount));
        set_ready(1);
        wait_drained("count drain");
        if (timed_out) return;
        wait_wrcount_zero("count drain");
        if (timed_out) return;
        checks++;
        if (rdcount !== '0 || empty !== 1'b1)
            report_error($sformatf("after drain rdcount %0d empty %b", rdcount, empty));
    endtask

    // the sink drives a ready level that changes only on falling rd edges
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge rd_clk);
            if (ready_mode == 2) out_ready = (rand_below(4) != 0);
            else out_ready = (ready_mode == 1);
        end
    end

    // compare process sampling out_valid where it is steady at the falling edge
    initial begin : compare
        cdc_stream_pkg::fifo_word_t exp;
        forever begin
            @(negedge rd_clk);
            if (out_valid === 1'b1) begin
                checks++;
                delivered++;
                if (exp_q.size() == 0) begin
                    report_error($sformatf("word %h delivered with none expected", out_word));
                end else begin
                    exp = exp_q.pop_front();
                    if (out_word !== exp)
                        report_error($sformatf("word %h, expected %h", out_word, exp));
                end
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        in_stb    = 1'b0;
        in_sample = '0;
        in_tag    = '0;
        repeat (3) @(negedge wr_clk);
        check_idle_state("during reset");
        repeat (2) @(negedge wr_clk);
        rst_n = 1'b1;                             // after 5 wr_clk cycles
        wr_idle(3);
        check_idle_state("after reset");
        end_test("test 1 reset state");
        if (!timed_out) begin
            test_in_order();
            end_test("test 2 in-order delivery");
        end
        if (!timed_out) begin
            test_overflow();
            end_test("test 3 overflow");
        end
        if (!timed_out) begin
            test_counts();
            end_test("test 4 occupancy counts");
        end
        if (!timed_out) begin
            wr_idle(4);
            checks++;
            if (pkt_count !== cdc_stream_pkg::pkt_count_t'(ref_pkts()))
                report_error($sformatf("pkt_count %0d, expected %0d", pkt_count, ref_pkts()));
            checks++;
            if (drop_count !== cdc_stream_pkg::drop_count_t'(exp_drops))
                report_error($sformatf("drop_count %0d, model %0d", drop_count, exp_drops));
            end_test("test 5 packet counting");
            repeat (50) begin                     // ready is still high here
                @(negedge rd_clk);
                checks++;
                if (out_valid !== 1'b0) report_error("out_valid with the fifo drained");
            end
            end_test("test 6 no spurious output");
        end
        checks++;
        if (UUT.u_fifo.u_chk.fails != 0)
            report_error($sformatf("fifo rule assertions failed %0d times",
                                   UUT.u_fifo.u_chk.fails));
        $display("summary: %0d of 6 tests passed, %0d checks, %0d errors",
                 tests_passed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/cdc_stream_chk.sv
// fifo rule checker asserting caller gating and flag and count agreement
`timescale 1ns/100ps

module cdc_stream_chk #(
    parameter int ADDR_W = 4
) (
    input logic            rst_n,
    input logic            wr_clk,
    input logic            wr_en,
    input logic            full,
    input logic [ADDR_W:0] wrcount,
    input logic            rd_clk,
    input logic            rd_en,
    input logic            empty,
    input logic [ADDR_W:0] rdcount
);

    typedef logic [ADDR_W:0] count_t;

    localparam count_t DEPTH_C = count_t'(1 << ADDR_W);

    int fails = 0;   // count of failed assertions for the testbench summary

    // the fifo takes every strobe so the packer and unpacker must gate them
    wr_gated: assert property (@(posedge wr_clk) disable iff (!rst_n) wr_en |-> !full)
        else begin
            fails++;
            $error("write strobe while fifo full");
        end

    rd_gated: assert property (@(posedge rd_clk) disable iff (!rst_n) rd_en |-> !empty)
        else begin
            fails++;
            $error("read strobe while fifo empty");
        end

    // full means a whole lap between the pointers
    full_cnt: assert property (@(posedge wr_clk) disable iff (!rst_n)
                               full == (wrcount == DEPTH_C))
        else begin
            fails++;
            $error("full and wrcount disagree");
        end

    wr_range: assert property (@(posedge wr_clk) disable iff (!rst_n) wrcount <= DEPTH_C)
        else begin
            fails++;
            $error("wrcount above depth");
        end

    empty_cnt: assert property (@(posedge rd_clk) disable iff (!rst_n)
                                empty == (rdcount == '0))
        else begin
            fails++;
            $error("empty and rdcount disagree");
        end

    rd_range: assert property (@(posedge rd_clk) disable iff (!rst_n) rdcount <= DEPTH_C)
        else begin
            fails++;
            $error("rdcount above depth");
        end

endmodule

bind async_fifo cdc_stream_chk #(.ADDR_W(ADDR_W)) u_chk (
    .rst_n   (rst_n),
    .wr_clk  (wr_clk),
    .wr_en   (wr_en),
    .full    (full),
    .wrcount (wrcount),
    .rd_clk  (rd_clk),
    .rd_en   (rd_en),
    .empty   (empty),
    .rdcount (rdcount)
);

// File: hdl/cdc_stream_top.sv
// cdc stream top: packer, async fifo and unpacker carrying framed samples between two clocks
`timescale 1ns/100ps

module cdc_stream_top #(
    parameter int ADDR_W = cdc_stream_pkg::ADDR_W_DEF   // fifo depth exponent
) (
    input  logic                        rst_n,       // async, both domains
    // write domain
    input  logic                        wr_clk,
    input  logic                        in_stb,
    input  cdc_stream_pkg::sample_t     in_sample,
    input  cdc_stream_pkg::stream_tag_t in_tag,
    output logic                        full,
    output logic [ADDR_W:0]             wrcount,
    output cdc_stream_pkg::drop_count_t drop_count,
    // read domain
    input  logic                        rd_clk,
    input  logic                        out_ready,
    output logic                        out_valid,
    output cdc_stream_pkg::fifo_word_t  out_word,
    output cdc_stream_pkg::pkt_count_t  pkt_count,
    output logic                        empty,
    output logic [ADDR_W:0]             rdcount
);

    logic                       wr_en;     // packer -> fifo
    cdc_stream_pkg::fifo_word_t wr_word;
    logic                       rd_en;     // unpacker -> fifo
    cdc_stream_pkg::fifo_word_t rd_word;   // fifo head

    stream_packer u_packer (
        .wr_clk     (wr_clk),
        .rst_n      (rst_n),
        .in_stb     (in_stb),
        .in_sample  (in_sample),
        .in_tag     (in_tag),
        .full       (full),
        .wr_en      (wr_en),
        .wr_word    (wr_word),
        .drop_count (drop_count)
    );

    async_fifo #(
        .DSIZE  (cdc_stream_pkg::DATA_W),
        .ADDR_W (ADDR_W)
    ) u_fifo (
        .rst_n   (rst_n),
        .wr_clk  (wr_clk),
        .wr_en   (wr_en),
        .din     (wr_word),
        .full    (full),
        .wrcount (wrcount),
        .rd_clk  (rd_clk),
        .rd_en   (rd_en),
        .dout    (rd_word),
        .empty   (empty),
        .rdcount (rdcount)
    );

    stream_unpacker u_unpacker (
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .out_ready (out_ready),
        .empty     (empty),
        .rd_word   (rd_word),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .out_word  (out_word),
        .pkt_count (pkt_count)
    );

endmodule

// File: hdl/stream_unpacker.sv
// stream unpacker: pops fifo words under a ready level, presents them with a strobe, counts packets
`timescale 1ns/100ps

module stream_unpacker (
    input  logic                       rd_clk,
    input  logic                       rst_n,
    input  logic                       out_ready,   // level from the sink
    input  logic                       empty,       // fifo empty, read domain
    input  cdc_stream_pkg::fifo_word_t rd_word,     // fifo head word
    output logic                       rd_en,       // pop pulse
    output logic                       out_valid,   // one cycle per delivered word
    output cdc_stream_pkg::fifo_word_t out_word,
    output cdc_stream_pkg::pkt_count_t pkt_count
);

    logic last_pop;   // popping the closing word of a packet

    // pop whenever the sink wants data and the head is valid
    // read gating lives here, the fifo never checks empty again
    assign rd_en = out_ready && !empty;

    assign last_pop = rd_en && rd_word.tag.eof;

    // output strobe, one rd_clk after the pop
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    // word capture at the pop edge
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            out_word <= rd_word;   // sof/eof travel with the sample
        end
    end

    // packet counter, bumps on each popped eof and wraps
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count <= '0;
        end else if (last_pop) begin
            pkt_count <= pkt_count + 1'b1;
        end
    end

endmodule

// File: hdl/async_fifo.sv
// async fifo that buffers words across two clocks with gray pointers, flags and counts
`timescale 1ns/100ps

module async_fifo #(
    parameter int DSIZE  = cdc_stream_pkg::DATA_W,      // data width
    parameter int ADDR_W = cdc_stream_pkg::ADDR_W_DEF   // depth is 2**ADDR_W
) (
    input  logic              rst_n,     // clears both domains
    // write side
    input  logic              wr_clk,
    input  logic              wr_en,     // caller guarantees !full
    input  logic [DSIZE-1:0]  din,
    output logic              full,
    output logic [ADDR_W:0]   wrcount,   // may overstate occupancy
    // read side
    input  logic              rd_clk,
    input  logic              rd_en,     // caller guarantees !empty
    output logic [DSIZE-1:0]  dout,      // head word while !empty
    output logic              empty,
    output logic [ADDR_W:0]   rdcount    // may understate occupancy
);

    localparam int DEPTH = 1 << ADDR_W;

    typedef logic [ADDR_W:0]   ptr_t;    // address plus wrap bit
    typedef logic [ADDR_W-1:0] addr_t;   // memory index
    typedef logic [DSIZE-1:0]  data_t;

    // binary to gray
    function automatic ptr_t bin2gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    // gray to binary by xoring down from the msb
    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        int   i;
        b[ADDR_W] = g[ADDR_W];
        for (i = ADDR_W - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    data_t mem [DEPTH];                  // entry storage

    // write domain state
    ptr_t wbin;                          // binary write pointer
    ptr_t wgray;                         // gray write pointer seen by the read side
    ptr_t rgray_s1;                      // first sync flop for the read gray pointer
    ptr_t rgray_s2;                      // second sync flop for the read gray pointer
    ptr_t rbin_w;                        // synced read pointer back in binary

    // read domain state
    ptr_t rbin;                          // binary read pointer
    ptr_t rgray;                         // gray read pointer seen by the write side
    ptr_t wgray_s1;                      // first sync flop for the write gray pointer
    ptr_t wgray_s2;                      // second sync flop for the write gray pointer
    ptr_t wbin_r;                        // synced write pointer back in binary

    // write clock domain

    // memory write takes every wr_en as is
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[addr_t'(wbin)] <= din;
        end
    end

    // write pointer with a registered gray copy so only one bit moves per step
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wbin  <= '0;
            wgray <= '0;
        end else if (wr_en) begin
            wbin  <= wbin + 1'b1;
            wgray <= bin2gray(wbin + 1'b1);
        end
    end

    // read pointer into write clock domain
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            rgray_s1 <= '0;
            rgray_s2 <= '0;
        end else begin
            rgray_s1 <= rgray;
            rgray_s2 <= rgray_s1;
        end
    end

    assign rbin_w = gray2bin(rgray_s2);

    // full when the write side is one lap ahead
    // in gray code that means the top two bits inverted and the rest equal
    assign full = (wgray == {~rgray_s2[ADDR_W:ADDR_W-1], rgray_s2[ADDR_W-2:0]});

    assign wrcount = wbin - rbin_w;      // stale read pointer makes this pessimistic

    // read clock domain

    // fall-through read straight off the array
    assign dout = mem[addr_t'(rbin)];

    // read pointer advances on a pop
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rbin  <= '0;
            rgray <= '0;
        end else if (rd_en) begin
            rbin  <= rbin + 1'b1;
            rgray <= bin2gray(rbin + 1'b1);
        end
    end

    // write pointer into read clock domain
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            wgray_s1 <= '0;
            wgray_s2 <= '0;
        end else begin
            wgray_s1 <= wgray;
            wgray_s2 <= wgray_s1;
        end
    end

    assign wbin_r = gray2bin(wgray_s2);

    // empty when both pointers match including the wrap bit
    assign empty = (rgray == wgray_s2);

    assign rdcount = wbin_r - rbin;      // stale write pointer makes this lag new data

endmodule

// File: hdl/stream_packer.sv
// stream packer: registers framed samples and writes them to the fifo, counting drops when full
`timescale 1ns/100ps

module stream_packer (
    input  logic                        wr_clk,
    input  logic                        rst_n,
    input  logic                        in_stb,      // one pulse per sample
    input  cdc_stream_pkg::sample_t     in_sample,
    input  cdc_stream_pkg::stream_tag_t in_tag,
    input  logic                        full,        // fifo full, write domain
    output logic                        wr_en,       // one-cycle write pulse
    output cdc_stream_pkg::fifo_word_t  wr_word,
    output cdc_stream_pkg::drop_count_t drop_count
);

    logic                       stb_q;   // registered strobe, a word is waiting
    cdc_stream_pkg::fifo_word_t word_q;  // registered sample with its flags
    logic                       drop;    // waiting word meets a full fifo

    // input stage
    // a new strobe simply overwrites the stage, the old word leaves at the same edge
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            stb_q <= 1'b0;
        end else begin
            stb_q <= in_stb;
        end
    end

    // payload only loads on a strobe
    always_ff @(posedge wr_clk) begin
        if (in_stb) begin
            word_q.tag    <= in_tag;
            word_q.sample <= in_sample;
        end
    end

    // write gating lives here, the fifo itself takes every wr_en
    assign wr_en   = stb_q && !full;
    assign drop    = stb_q && full;   // no stall upstream, the sample is lost
    assign wr_word = word_q;

    // drop counter, holds at all ones
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

// File: hdl/cdc_stream_pkg.sv
// cdc stream package: sample, framing tag, fifo word and counter types shared by the design

package cdc_stream_pkg;

    // raw sample carried across the clock boundary
    typedef logic [15:0] sample_t;

    // packet framing flags riding along with each sample
    typedef struct packed {
        logic sof;                          // first sample of a packet
        logic eof;                          // last sample of a packet
    } stream_tag_t;

    // one fifo entry, tag in the two upper bits
    typedef struct packed {
        stream_tag_t tag;
        sample_t     sample;
    } fifo_word_t;

    // fifo data width, 18 bits like the block ram primitive port
    localparam int DATA_W = $bits(fifo_word_t);

    // default depth exponent, 16 entries
    localparam int ADDR_W_DEF = 4;

    // samples rejected on full (write domain)
    typedef logic [15:0] drop_count_t;

    // packets delivered on the read side
    typedef logic [15:0] pkt_count_t;

endpackage
